//--- bench/rv_core_properties.sv
`include "rv_core_defines.svh"

module rv_core_properties (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     psel,
  input logic                     penable,
  input logic                     pwrite,
  input logic [11:0]              paddr,
  input logic                     pready,
  input logic                     pslverr,
  input logic                     start,
  input rv_core_pkg::core_state_e state,
  input logic                     halted,
  input logic [`RV_XLEN-1:0]      a0
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_core_pkg::*;

  int unsigned fail_count;
  logic        access;
  logic        mapped;

  initial fail_count = 0;

  assign access = psel && penable;
  assign mapped = (paddr < `RV_CTRL_ADDR) || (paddr == `RV_CTRL_ADDR) ||
                  (paddr == `RV_STATUS_ADDR);

  // Zero wait states
  pready_high: assert property (@(posedge clk) disable iff (!arst_n)
    access |-> pready)
    else begin
      fail_count++;
      $error("pready low in an APB access phase");
    end

  // Program memory is locked while the core runs
  write_locked: assert property (@(posedge clk) disable iff (!arst_n)
    access && pwrite && (paddr < `RV_CTRL_ADDR) && (state == ST_RUN) |-> pslverr)
    else begin
      fail_count++;
      $error("instruction memory write during RUN without pslverr");
    end

  unmapped_err: assert property (@(posedge clk) disable iff (!arst_n)
    access && !mapped |-> pslverr)
    else begin
      fail_count++;
      $error("access to an unmapped address without pslverr");
    end

  // Only a new start takes the core out of HALTED
  halted_held: assert property (@(posedge clk) disable iff (!arst_n)
    halted && !start |=> halted)
    else begin
      fail_count++;
      $error("halted fell without a start or reset");
    end

  a0_stable: assert property (@(posedge clk) disable iff (!arst_n)
    halted && !start |=> $stable(a0))
    else begin
      fail_count++;
      $error("a0 changed while the core was halted");
    end

endmodule

bind rv_core_top rv_core_properties props (
  .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
  .paddr(paddr), .pready(pready), .pslverr(pslverr), .start(start), .state(state),
  .halted(halted), .a0(a0)
);

//--- bench/tb_rv_core.sv
`include "rv_core_defines.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD    = 40;
  localparam int          HALT_TIMEOUT  = 4000;
  localparam int          READY_TIMEOUT = 16;
  localparam logic [31:0] STATUS_RUN    = 32'd1;
  localparam logic [31:0] STATUS_HALTED = 32'd2;
  localparam logic [11:0] UNMAPPED_ADDR = 12'h408;

  // RV32I major opcodes
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LOAD   = 7'b0000011;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] a0;
  logic        halted;

  logic [31:0] image [$];
  logic [31:0] expected_a0;
  logic [31:0] rdata;
  logic        err;
  int          seed;
  int          n;

  rv_core_top dut (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .a0(a0), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else stop_with_failure($sformatf("Mismatch at %0d ns: %s = 0x%08h, expected 0x%08h",
                                     $time, name, got, exp));
  endtask

  always @(negedge clk) begin
    if (dut.props.fail_count != 0) stop_with_failure("a bound APB or status assertion failed");
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program(input int count);
    image.delete();
    image.push_back(i_type(12'(count), 5'd0, 3'b000, 5'd5, OP_IMM));
    image.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd6, OP_IMM));
    image.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd7, OP_IMM));
    // Loop body at word 3
    image.push_back(i_type(12'd1, 5'd7, 3'b000, 5'd7, OP_IMM));
    image.push_back(r_type(7'h00, 5'd7, 5'd6, 3'b000, 5'd6));
    image.push_back(b_type(13'h1ff8, 5'd5, 5'd7, 3'b001));
    image.push_back(s_type(12'd64, 5'd6, 5'd0));
    image.push_back(i_type(12'd64, 5'd0, 3'b010, 5'd8, LOAD));
    image.push_back({20'h12345, 5'd9, 7'b0110111});
    image.push_back(r_type(7'h20, 5'd8, 5'd9, 3'b000, 5'd11));
    image.push_back(r_type(7'h00, 5'd8, 5'd11, 3'b100, 5'd12));
    image.push_back(r_type(7'h00, 5'd9, 5'd12, 3'b111, 5'd13));
    image.push_back(r_type(7'h00, 5'd8, 5'd13, 3'b110, 5'd14));
    image.push_back(r_type(7'h00, 5'd9, 5'd8, 3'b010, 5'd15));
    // Subroutine call over two words that must never execute
    image.push_back(j_type(21'd12, 5'd1));
    image.push_back(i_type(12'hfff, 5'd0, 3'b000, 5'd10, OP_IMM));
    image.push_back(i_type(12'hfff, 5'd0, 3'b000, 5'd10, OP_IMM));
    image.push_back(r_type(7'h00, 5'd15, 5'd14, 3'b000, 5'd10));
    image.push_back(r_type(7'h00, 5'd1, 5'd10, 3'b000, 5'd10));
    image.push_back(32'h00000073);
  endtask

  function automatic logic [31:0] program_result(input int count);
    logic [31:0] sum;
    logic [31:0] upper;
    logic [31:0] diff;
    logic [31:0] mixed;
    logic [31:0] masked;
    logic [31:0] merged;
    logic [31:0] less;
    sum    = 32'(count * (count + 1) / 2);
    upper  = 32'h12345000;
    diff   = upper - sum;
    mixed  = diff ^ sum;
    masked = mixed & upper;
    merged = masked | sum;
    less   = ($signed(sum) < $signed(upper)) ? 32'd1 : 32'd0;
    // The JAL at word 14 links byte address 60
    return merged + less + 32'd60;
  endfunction

  task automatic transfer(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] data,
                          output logic slverr);
    int cycles;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    cycles  = 0;
    @(posedge clk);
    while (!pready) begin
      if (cycles == READY_TIMEOUT) stop_with_failure("APB slave never raised pready");
      cycles++;
      @(posedge clk);
    end
    data   = prdata;
    slverr = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_image();
    logic [31:0] data;
    logic        slverr;
    foreach (image[i]) begin
      transfer(1'b0, 12'(i * 4), 32'd0, data, slverr);
      check_value($sformatf("prdata of imem[%0d]", i), data, image[i]);
    end
  endtask

  task automatic run_program();
    logic [31:0] data;
    logic        slverr;
    int          cycles;
    transfer(1'b1, `RV_CTRL_ADDR, 32'd1, data, slverr);
    transfer(1'b0, `RV_STATUS_ADDR, 32'd0, data, slverr);
    check_value("prdata of status", data, STATUS_RUN);
    transfer(1'b1, 12'h000, ~image[0], data, slverr);
    assert (slverr)
    else stop_with_failure("instruction memory write during RUN was not refused");
    cycles = 0;
    while (!halted) begin
      if (cycles == HALT_TIMEOUT) stop_with_failure("core did not halt before the timeout");
      cycles++;
      @(negedge clk);
    end
    check_value("a0", a0, expected_a0);
    transfer(1'b0, `RV_STATUS_ADDR, 32'd0, data, slverr);
    check_value("prdata of status", data, STATUS_HALTED);
  endtask

  initial begin
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 12'h000;
    pwdata  = 32'd0;
    seed    = 32'h64b4143e;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    n = 1 + int'($unsigned($random(seed)) % 32'd20);
    build_program(n);
    expected_a0 = program_result(n);

    foreach (image[i]) transfer(1'b1, 12'(i * 4), image[i], rdata, err);
    check_image();

    transfer(1'b0, UNMAPPED_ADDR, 32'd0, rdata, err);
    assert (err) else stop_with_failure("unmapped address read did not return pslverr");

    run_program();
    // Word 0 must still hold the original program after the refused write
    check_image();
    run_program();

    if (dut.props.fail_count != 0) begin
      stop_with_failure("a bound APB or status assertion failed");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- design/alu.sv
`include "rv_core_defines.svh"

module alu (
  input  logic [`RV_XLEN-1:0]    a,
  input  logic [`RV_XLEN-1:0]    b,
  input  rv_core_pkg::alu_op_e   op,
  output logic [`RV_XLEN-1:0]    y,
  output logic                   eq
);
  import rv_core_pkg::*;

  always_comb begin
    case (op)
      ALU_SUB:    y = a - b;
      ALU_AND:    y = a & b;
      ALU_OR:     y = a | b;
      ALU_XOR:    y = a ^ b;
      ALU_SLT:    y = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_PASS_B: y = b;
      default:    y = a + b;
    endcase
  end

  // Branch compare
  assign eq = (a == b);

endmodule

//--- design/control_unit.sv
`include "rv_core_defines.svh"

module control_unit (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`RV_XLEN-1:0]       instr,
  input  logic                      start,
  input  logic                      halt_exec,
  decode_if.ctrl                    decode,
  output logic                      run,
  output rv_core_pkg::core_state_e  state,
  output logic                      halted
);
  import rv_core_pkg::*;

  core_state_e state_nxt;
  logic [2:0]  funct3;
  logic        funct7_b5;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE, ST_HALTED: if (start) state_nxt = ST_RUN;
      ST_RUN:             if (halt_exec) state_nxt = ST_HALTED;
      default:            state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign run    = (state == ST_RUN);
  assign halted = (state == ST_HALTED);

  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  assign decode.rs1 = instr[19:15];
  assign decode.rs2 = instr[24:20];
  assign decode.rd  = instr[11:7];

  // Decoder and immediate generator
  // Unknown opcodes fall through as a no-op
  always_comb begin
    decode.reg_write   = 1'b0;
    decode.mem_write   = 1'b0;
    decode.alu_src_imm = 1'b0;
    decode.alu_op      = ALU_ADD;
    decode.result_src  = RES_ALU;
    decode.branch      = 1'b0;
    decode.branch_ne   = 1'b0;
    decode.jump        = 1'b0;
    decode.halt        = 1'b0;
    decode.imm         = {{20{instr[31]}}, instr[31:20]};
    case (opcode_e'(instr[6:0]))
      OPC_OP: begin
        decode.reg_write = 1'b1;
        case (funct3)
          3'b000:  decode.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
          3'b010:  decode.alu_op = ALU_SLT;
          3'b100:  decode.alu_op = ALU_XOR;
          3'b110:  decode.alu_op = ALU_OR;
          3'b111:  decode.alu_op = ALU_AND;
          default: decode.reg_write = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // ADDI only
        decode.reg_write   = (funct3 == 3'b000);
        decode.alu_src_imm = 1'b1;
      end
      OPC_LUI: begin
        decode.reg_write   = 1'b1;
        decode.alu_src_imm = 1'b1;
        decode.alu_op      = ALU_PASS_B;
        decode.imm         = {instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        decode.reg_write   = (funct3 == 3'b010);
        decode.alu_src_imm = 1'b1;
        decode.result_src  = RES_MEM;
      end
      OPC_STORE: begin
        decode.mem_write   = (funct3 == 3'b010);
        decode.alu_src_imm = 1'b1;
        decode.imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OPC_BRANCH: begin
        decode.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
        decode.branch_ne = funct3[0];
        decode.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        decode.reg_write  = 1'b1;
        decode.jump       = 1'b1;
        decode.result_src = RES_PC_PLUS4;
        decode.imm        = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
      end
      OPC_SYSTEM: decode.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- design/data_memory.sv
`include "rv_core_defines.svh"

module data_memory (
  input  logic                   clk,
  input  logic                   we,
  input  logic [`RV_DMEM_AW-1:0] addr,
  input  logic [`RV_XLEN-1:0]    wdata,
  output logic [`RV_XLEN-1:0]    rdata
);

  logic [`RV_XLEN-1:0] mem [0:(1<<`RV_DMEM_AW)-1];

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
  end

  // Load data is ready within the execute cycle
  assign rdata = mem[addr];

endmodule

//--- design/decode_if.sv
`include "rv_core_defines.svh"

interface decode_if;
  import rv_core_pkg::*;

  logic                  reg_write;
  logic                  mem_write;
  logic                  alu_src_imm;
  alu_op_e               alu_op;
  result_src_e           result_src;
  logic                  branch;
  logic                  branch_ne;
  logic                  jump;
  logic                  halt;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;

  modport ctrl(output reg_write, mem_write, alu_src_imm, alu_op, result_src, branch,
               branch_ne, jump, halt, imm, rs1, rs2, rd);
  modport dp(input reg_write, mem_write, alu_src_imm, alu_op, result_src, branch,
             branch_ne, jump, halt, imm, rs1, rs2, rd);
endinterface

//--- design/instr_mem_apb.sv
`include "rv_core_defines.svh"

module instr_mem_apb (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [11:0]               paddr,
  input  logic [`RV_XLEN-1:0]       pwdata,
  output logic [`RV_XLEN-1:0]       prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic [`RV_IMEM_AW-1:0]    fetch_addr,
  output logic [`RV_XLEN-1:0]       fetch_instr,
  input  rv_core_pkg::core_state_e  state,
  output logic                      start
);
  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0]    mem [0:(1<<`RV_IMEM_AW)-1];
  logic                   access;
  logic                   hit_imem;
  logic                   hit_ctrl;
  logic                   hit_status;
  logic [`RV_IMEM_AW-1:0] word_idx;

  assign access     = psel && penable;
  assign hit_imem   = (paddr < `RV_CTRL_ADDR);
  assign hit_ctrl   = (paddr == `RV_CTRL_ADDR);
  assign hit_status = (paddr == `RV_STATUS_ADDR);
  assign word_idx   = paddr[`RV_IMEM_AW+1:2];

  // Zero wait states on every transfer
  assign pready = 1'b1;

  // Program may only change while the core is stopped
  assign pslverr = access && ((hit_imem && pwrite && (state == ST_RUN)) ||
                              !(hit_imem || hit_ctrl || hit_status));

  always_comb begin
    prdata = '0;
    if (hit_imem) prdata = mem[word_idx];
    else if (hit_status) prdata = {{(`RV_XLEN-2){1'b0}}, state};
  end

  always_ff @(posedge clk) begin
    if (access && pwrite && hit_imem && (state != ST_RUN)) mem[word_idx] <= pwdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start <= 1'b0;
    end else begin
      start <= access && pwrite && hit_ctrl && pwdata[0];
    end
  end

  assign fetch_instr = mem[fetch_addr];

endmodule

//--- design/pipeline_datapath.sv
`include "rv_core_defines.svh"

module pipeline_datapath (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  output logic [`RV_IMEM_AW-1:0] fetch_addr,
  input  logic [`RV_XLEN-1:0]    fetch_instr,
  output logic [`RV_XLEN-1:0]    decode_instr,
  decode_if.dp                   decode,
  output logic                   halt_exec,
  output logic [`RV_XLEN-1:0]    a0
);
  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] if_pc;
  logic                if_valid;
  logic [`RV_XLEN-1:0] rd1;
  logic [`RV_XLEN-1:0] rd2;

  // Decode to execute register
  logic                  ex_valid;
  logic [`RV_XLEN-1:0]   ex_pc;
  logic [`RV_XLEN-1:0]   ex_rd1;
  logic [`RV_XLEN-1:0]   ex_rd2;
  logic [`RV_XLEN-1:0]   ex_imm;
  logic [`RV_REG_AW-1:0] ex_rd;
  logic                  ex_reg_write;
  logic                  ex_mem_write;
  logic                  ex_alu_src_imm;
  alu_op_e               ex_alu_op;
  result_src_e           ex_result_src;
  logic                  ex_branch;
  logic                  ex_branch_ne;
  logic                  ex_jump;
  logic                  ex_halt;

  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic                alu_eq;
  logic [`RV_XLEN-1:0] mem_rdata;
  logic [`RV_XLEN-1:0] wb_data;
  logic                taken;

  assign fetch_addr = pc[`RV_IMEM_AW+1:2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= '0;
      if_valid <= 1'b0;
      ex_valid <= 1'b0;
    end else if (run) begin
      if (halt_exec) begin
        // Park at the reset vector so a new start refetches from 0
        pc       <= '0;
        if_valid <= 1'b0;
        ex_valid <= 1'b0;
      end else if (taken) begin
        pc       <= ex_pc + ex_imm;
        if_valid <= 1'b0;
        ex_valid <= 1'b0;
      end else begin
        pc       <= pc + 32'd4;
        if_valid <= 1'b1;
        ex_valid <= if_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      decode_instr   <= fetch_instr;
      if_pc          <= pc;
      ex_pc          <= if_pc;
      ex_rd1         <= rd1;
      ex_rd2         <= rd2;
      ex_imm         <= decode.imm;
      ex_rd          <= decode.rd;
      ex_reg_write   <= decode.reg_write;
      ex_mem_write   <= decode.mem_write;
      ex_alu_src_imm <= decode.alu_src_imm;
      ex_alu_op      <= decode.alu_op;
      ex_result_src  <= decode.result_src;
      ex_branch      <= decode.branch;
      ex_branch_ne   <= decode.branch_ne;
      ex_jump        <= decode.jump;
      ex_halt        <= decode.halt;
    end
  end

  register_file u_regs (
    .clk(clk), .we(ex_valid && ex_reg_write), .ra1(decode.rs1), .ra2(decode.rs2),
    .wa(ex_rd), .wd(wb_data), .rd1(rd1), .rd2(rd2), .a0(a0)
  );

  assign alu_b = ex_alu_src_imm ? ex_imm : ex_rd2;

  alu u_alu (.a(ex_rd1), .b(alu_b), .op(ex_alu_op), .y(alu_y), .eq(alu_eq));

  data_memory u_dmem (
    .clk(clk), .we(ex_valid && ex_mem_write), .addr(alu_y[`RV_DMEM_AW+1:2]),
    .wdata(ex_rd2), .rdata(mem_rdata)
  );

  always_comb begin
    case (ex_result_src)
      RES_MEM:      wb_data = mem_rdata;
      RES_PC_PLUS4: wb_data = ex_pc + 32'd4;
      default:      wb_data = alu_y;
    endcase
  end

  assign taken     = ex_valid && (ex_jump || (ex_branch && (alu_eq != ex_branch_ne)));
  assign halt_exec = ex_valid && ex_halt;

endmodule

//--- design/register_file.sv
`include "rv_core_defines.svh"

module register_file (
  input  logic                  clk,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] ra1,
  input  logic [`RV_REG_AW-1:0] ra2,
  input  logic [`RV_REG_AW-1:0] wa,
  input  logic [`RV_XLEN-1:0]   wd,
  output logic [`RV_XLEN-1:0]   rd1,
  output logic [`RV_XLEN-1:0]   rd2,
  output logic [`RV_XLEN-1:0]   a0
);

  logic [`RV_XLEN-1:0] regs [0:(1<<`RV_REG_AW)-1];

  always_ff @(posedge clk) begin
    if (we && (wa != '0)) regs[wa] <= wd;
  end

  // Write-through so decode sees the result leaving execute
  assign rd1 = (ra1 == '0) ? '0 : (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && (wa == ra2)) ? wd : regs[ra2];

  assign a0 = regs[10];

endmodule

//--- design/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Datapath and register address widths
`define RV_XLEN 32
`define RV_REG_AW 5

// Word address widths of the two memories
`define RV_IMEM_AW 8
`define RV_DMEM_AW 8

// Host register map
`define RV_CTRL_ADDR 12'h400
`define RV_STATUS_ADDR 12'h404

`endif

//--- design/rv_core_pkg.sv
package rv_core_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC_PLUS4
  } result_src_e;

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HALTED} core_state_e;

endpackage

//--- design/rv_core_top.sv
`include "rv_core_defines.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [11:0]         paddr,
  input  logic [`RV_XLEN-1:0] pwdata,
  output logic [`RV_XLEN-1:0] prdata,
  output logic                pready,
  output logic                pslverr,
  output logic [`RV_XLEN-1:0] a0,
  output logic                halted
);
  import rv_core_pkg::*;

  logic [`RV_IMEM_AW-1:0] fetch_addr;
  logic [`RV_XLEN-1:0]    fetch_instr;
  logic [`RV_XLEN-1:0]    decode_instr;
  logic                   start;
  logic                   run;
  logic                   halt_exec;
  core_state_e            state;

  decode_if dec_if ();

  instr_mem_apb u_imem (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fetch_addr(fetch_addr), .fetch_instr(fetch_instr), .state(state), .start(start)
  );

  control_unit u_ctrl (
    .clk(clk), .arst_n(arst_n), .instr(decode_instr), .start(start),
    .halt_exec(halt_exec), .decode(dec_if.ctrl), .run(run), .state(state),
    .halted(halted)
  );

  pipeline_datapath u_dp (
    .clk(clk), .arst_n(arst_n), .run(run), .fetch_addr(fetch_addr),
    .fetch_instr(fetch_instr), .decode_instr(decode_instr), .decode(dec_if.dp),
    .halt_exec(halt_exec), .a0(a0)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, the exit status gives the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_core -f rv_core.f -o sim_rv_core &&
  ./obj_dir/sim_rv_core +verilator+error+limit+100 ||
  exit 1

//--- rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/decode_if.sv
design/control_unit.sv
design/instr_mem_apb.sv
design/register_file.sv
design/alu.sv
design/data_memory.sv
design/pipeline_datapath.sv
design/rv_core_top.sv
bench/rv_core_properties.sv
bench/tb_rv_core.sv
